// ==== compile.f ====
source/bpu_pkg.sv
source/bimodal_predictor.sv
source/branch_target_buffer.sv
source/next_pc_select.sv
source/bpu_top.sv
tests/bpu_checker.sv
tests/bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module bpu_tb -f compile.f -o bpu_sim > sim.log 2>&1 &&
./obj_dir/bpu_sim >> sim.log 2>&1
grep -q "All checks passed" sim.log && echo "simulation PASS" || {
    echo "simulation FAIL, see sim.log"
    exit 1
}

// ==== source/bimodal_predictor.sv ====
`timescale 1ns/1ps

module bimodal_predictor (
    input  logic           clk,
    input  logic           rst,
    // fetch lookup
    input  bpu_pkg::addr_t if_pc_i,
    // resolved outcome from execute
    input  logic           ex_valid_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t ex_pc_i,
    output logic           taken_o
);

    import bpu_pkg::*;

    ctr_t     ctr_q [BIM_ENTRIES];
    bim_idx_t rd_idx;
    bim_idx_t wr_idx;
    ctr_t     wr_ctr;
    ctr_t     ctr_next;

    assign rd_idx = bim_index(if_pc_i);
    assign wr_idx = bim_index(ex_pc_i);

    // msb of the counter is the prediction
    assign taken_o = ctr_q[rd_idx][1];

    assign wr_ctr = ctr_q[wr_idx];

    // one step toward the outcome with saturation at 0 and 3
    always_comb begin
        ctr_next = wr_ctr;
        if (ex_taken_i) begin
            if (wr_ctr != 2'd3) begin
                ctr_next = wr_ctr + 2'd1;
            end
        end else begin
            if (wr_ctr != 2'd0) begin
                ctr_next = wr_ctr - 2'd1;
            end
        end
    end

    // lookup reads the old value in the update cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIM_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (ex_valid_i) begin
            ctr_q[wr_idx] <= ctr_next;
        end
    end

endmodule

// ==== source/bpu_pkg.sv ====
package bpu_pkg;

    // basic datapath widths
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;   // pc or branch target
    typedef logic [XLEN-1:0] inst_t;   // raw instruction word
    typedef logic [1:0]      ctr_t;    // 2-bit saturating counter

    // direction table indexed by pc[7:2]
    localparam int BIM_ENTRIES = 64;
    localparam int BIM_IDX_W   = $clog2(BIM_ENTRIES);
    typedef logic [BIM_IDX_W-1:0] bim_idx_t;

    // target buffer indexed by pc[5:2] and tagged with pc[31:6]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = XLEN - BTB_IDX_W - 2;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    localparam ctr_t CTR_RESET = 2'd1;   // weakly not-taken

    // rv32 major opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // instructions are word aligned, so pc[1:0] never enters an index
    function automatic bim_idx_t bim_index(addr_t pc);
        return pc[BIM_IDX_W+1:2];
    endfunction

    function automatic btb_idx_t btb_index(addr_t pc);
        return pc[BTB_IDX_W+1:2];
    endfunction

    function automatic btb_tag_t btb_tag(addr_t pc);
        return pc[XLEN-1:BTB_IDX_W+2];
    endfunction

endpackage

// ==== source/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top (
    input  logic           clk,
    input  logic           rst,
    // fetch stage
    input  bpu_pkg::addr_t if_pc_i,
    input  bpu_pkg::inst_t if_inst_i,
    // execute feedback
    input  logic           ex_valid_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    // prediction
    output logic           is_ctrl_o,
    output logic           pred_taken_o,
    output bpu_pkg::addr_t pred_pc_o
);

    import bpu_pkg::*;

    logic  dir_taken;
    logic  btb_hit;
    addr_t btb_target;

    bimodal_predictor u_bim (
        .clk        (clk),
        .rst        (rst),
        .if_pc_i    (if_pc_i),
        .ex_valid_i (ex_valid_i),
        .ex_taken_i (ex_taken_i),
        .ex_pc_i    (ex_pc_i),
        .taken_o    (dir_taken)
    );

    branch_target_buffer u_btb (
        .clk         (clk),
        .rst         (rst),
        .if_pc_i     (if_pc_i),
        .ex_valid_i  (ex_valid_i),
        .ex_taken_i  (ex_taken_i),
        .ex_pc_i     (ex_pc_i),
        .ex_target_i (ex_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    // combines direction and target into the next pc
    next_pc_select u_sel (
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .dir_taken_i  (dir_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .is_ctrl_o    (is_ctrl_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

endmodule

// ==== source/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic           clk,
    input  logic           rst,
    // fetch lookup
    input  bpu_pkg::addr_t if_pc_i,
    // resolved outcome from execute
    input  logic           ex_valid_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    // lookup result
    output logic           hit_o,
    output bpu_pkg::addr_t target_o
);

    import bpu_pkg::*;

    // entry storage
    logic     valid_q  [BTB_ENTRIES];
    btb_tag_t tag_q    [BTB_ENTRIES];
    addr_t    target_q [BTB_ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic     wr_en;

    assign rd_idx = btb_index(if_pc_i);
    assign rd_tag = btb_tag(if_pc_i);

    assign wr_idx = btb_index(ex_pc_i);
    assign wr_tag = btb_tag(ex_pc_i);
    assign wr_en  = ex_valid_i & ex_taken_i;   // only taken branches allocate

    // direct mapped with a full tag compare
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // an aliasing branch simply overwrites the slot
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= ex_target_i;
        end
    end

endmodule

// ==== source/next_pc_select.sv ====
`timescale 1ns/1ps

module next_pc_select (
    input  bpu_pkg::addr_t if_pc_i,
    input  bpu_pkg::inst_t if_inst_i,
    // predictor results
    input  logic           dir_taken_i,
    input  logic           btb_hit_i,
    input  bpu_pkg::addr_t btb_target_i,
    // prediction
    output logic           is_ctrl_o,
    output logic           pred_taken_o,
    output bpu_pkg::addr_t pred_pc_o
);

    import bpu_pkg::*;

    logic [6:0] opcode;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    addr_t      b_off;
    addr_t      j_off;
    addr_t      seq_pc;
    addr_t      b_pc;
    addr_t      j_pc;

    assign opcode    = if_inst_i[6:0];
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);

    // b-type immediate with bit 0 implied zero
    assign b_off = {{(XLEN-12){if_inst_i[31]}},
                    if_inst_i[7],
                    if_inst_i[30:25],
                    if_inst_i[11:8],
                    1'b0};

    // j-type immediate
    assign j_off = {{(XLEN-20){if_inst_i[31]}},
                    if_inst_i[19:12],
                    if_inst_i[20],
                    if_inst_i[30:21],
                    1'b0};

    assign seq_pc = if_pc_i + addr_t'(4);
    assign b_pc   = if_pc_i + b_off;
    assign j_pc   = if_pc_i + j_off;

    always_comb begin
        is_ctrl_o    = is_branch | is_jal | is_jalr;
        pred_taken_o = 1'b0;
        pred_pc_o    = seq_pc;   // default fall-through
        if (is_branch) begin
            pred_taken_o = dir_taken_i;
            if (dir_taken_i) begin
                pred_pc_o = btb_hit_i ? btb_target_i : b_pc;
            end
        end else if (is_jal) begin
            pred_taken_o = 1'b1;   // unconditional
            pred_pc_o    = btb_hit_i ? btb_target_i : j_pc;
        end else if (is_jalr) begin
            // register target is known only to the buffer
            pred_taken_o = btb_hit_i;
            if (btb_hit_i) begin
                pred_pc_o = btb_target_i;
            end
        end
    end

endmodule

// ==== tests/bpu_checker.sv ====
`timescale 1ns/1ps

module bpu_checker (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t if_pc_i,
    input  bpu_pkg::inst_t if_inst_i,
    input  logic           is_ctrl_i,
    input  logic           pred_taken_i,
    input  bpu_pkg::addr_t pred_pc_i
);

    import bpu_pkg::*;

    logic ctrl_opcode;

    assign ctrl_opcode = (if_inst_i[6:0] == OPC_BRANCH) ||
                         (if_inst_i[6:0] == OPC_JAL) ||
                         (if_inst_i[6:0] == OPC_JALR);

    // only control transfers can be taken
    taken_needs_ctrl: assert property (@(posedge clk) pred_taken_i |-> is_ctrl_i)
        else $error("taken prediction on a non-control instruction");

    seq_pc_not_taken: assert property (
        @(posedge clk) !pred_taken_i |-> (pred_pc_i == if_pc_i + 32'd4))
        else $error("not-taken prediction with a next pc other than pc plus 4");

    // decode keeps working while the tables are held in reset
    ctrl_low_in_reset: assert property (
        @(posedge clk) (rst && !ctrl_opcode) |-> !is_ctrl_i)
        else $error("control flag raised for a non-control instruction during reset");

endmodule

// ==== tests/bpu_tb.sv ====
`timescale 1ns/1ps

module bpu_tb;

    import bpu_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int STEP_TOTAL   = RESET_CYCLES + 1 + 31;   // reset plus test steps
    localparam int CYCLE_LIMIT  = 4 * STEP_TOTAL;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

    logic  clk;
    logic  rst;
    addr_t if_pc;
    inst_t if_inst;
    logic  ex_valid;
    logic  ex_taken;
    addr_t ex_pc;
    addr_t ex_target;
    logic  is_ctrl;
    logic  pred_taken;
    addr_t pred_pc;

    // reference tables
    ctr_t     m_ctr   [BIM_ENTRIES];
    logic     m_valid [BTB_ENTRIES];
    btb_tag_t m_tag   [BTB_ENTRIES];
    addr_t    m_tgt   [BTB_ENTRIES];

    logic   exp_ctrl;
    logic   exp_taken;
    addr_t  exp_pc;
    integer seed;
    int     cycle_cnt;
    int     err_cnt;
    int     err_at_start;
    int     tests_ok;
    int     tests_bad;

    bpu_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc),
        .if_inst_i    (if_inst),
        .ex_valid_i   (ex_valid),
        .ex_taken_i   (ex_taken),
        .ex_pc_i      (ex_pc),
        .ex_target_i  (ex_target),
        .is_ctrl_o    (is_ctrl),
        .pred_taken_o (pred_taken),
        .pred_pc_o    (pred_pc)
    );

    bind bpu_top bpu_checker u_chk (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .is_ctrl_i    (is_ctrl_o),
        .pred_taken_i (pred_taken_o),
        .pred_pc_i    (pred_pc_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("simulation timed out after %0d cycles", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};   // word aligned
    endfunction

    function automatic addr_t rand_pc(input logic [5:0] idx);
        addr_t r;
        r = rand_addr();
        return {r[31:8], idx, 2'b00};
    endfunction

    // beq x1, x2 with the given offset
    function automatic inst_t enc_b(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    // off is the immediate the instruction was encoded with
    task automatic predict(input addr_t pc, input inst_t inst, input addr_t off);
        logic hit;
        logic dir;
        hit       = m_valid[pc[5:2]] && (m_tag[pc[5:2]] == pc[31:6]);
        dir       = m_ctr[pc[7:2]][1];
        exp_ctrl  = 1'b0;
        exp_taken = 1'b0;
        exp_pc    = pc + 32'd4;
        if (inst[6:0] == OPC_BRANCH) begin
            exp_ctrl  = 1'b1;
            exp_taken = dir;
            if (dir) begin
                exp_pc = hit ? m_tgt[pc[5:2]] : pc + off;
            end
        end else if (inst[6:0] == OPC_JAL) begin
            exp_ctrl  = 1'b1;
            exp_taken = 1'b1;
            exp_pc    = hit ? m_tgt[pc[5:2]] : pc + off;
        end else if (inst[6:0] == OPC_JALR) begin
            exp_ctrl  = 1'b1;
            exp_taken = hit;
            if (hit) begin
                exp_pc = m_tgt[pc[5:2]];
            end
        end
    endtask

    task automatic update_model();
        if (ex_valid) begin
            if (ex_taken && m_ctr[ex_pc[7:2]] != 2'd3) begin
                m_ctr[ex_pc[7:2]] = m_ctr[ex_pc[7:2]] + 2'd1;
            end else if (!ex_taken && m_ctr[ex_pc[7:2]] != 2'd0) begin
                m_ctr[ex_pc[7:2]] = m_ctr[ex_pc[7:2]] - 2'd1;
            end
            if (ex_taken) begin
                m_valid[ex_pc[5:2]] = 1'b1;
                m_tag[ex_pc[5:2]]   = ex_pc[31:6];
                m_tgt[ex_pc[5:2]]   = ex_target;
            end
        end
    endtask

    // inputs change on the falling edge and outputs settle well before the rising one
    task automatic run_cycle(input addr_t off);
        predict(if_pc, if_inst, off);
        #5;
        assert (is_ctrl === exp_ctrl) else begin
            $display("FAIL %0t is_ctrl_o expected %0b actual %0b", $time, exp_ctrl, is_ctrl);
            err_cnt++;
        end
        assert (pred_taken === exp_taken) else begin
            $display("FAIL %0t pred_taken_o expected %0b actual %0b",
                     $time, exp_taken, pred_taken);
            err_cnt++;
        end
        assert (pred_pc === exp_pc) else begin
            $display("FAIL %0t pred_pc_o expected %h actual %h", $time, exp_pc, pred_pc);
            err_cnt++;
        end
        @(posedge clk);
        update_model();
        @(negedge clk);
    endtask

    task automatic fetch(input addr_t pc, input inst_t inst, input addr_t off);
        if_pc    = pc;
        if_inst  = inst;
        ex_valid = 1'b0;
        run_cycle(off);
    endtask

    // resolve pc in execute while the same pc is being fetched
    task automatic train(input addr_t pc, input inst_t inst, input addr_t off,
                         input logic taken, input addr_t target);
        if_pc     = pc;
        if_inst   = inst;
        ex_valid  = 1'b1;
        ex_taken  = taken;
        ex_pc     = pc;
        ex_target = target;
        run_cycle(off);
        ex_valid  = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_at_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_cnt - err_at_start);
        end
        err_at_start = err_cnt;
    endtask

    initial begin
        addr_t pc_a;
        addr_t pc_b;
        addr_t tgt_a;
        addr_t tgt_b;
        addr_t off;
        inst_t inst;
        seed         = 32'h10db_16bc;
        clk          = 1'b0;
        rst          = 1'b1;
        if_pc        = '0;
        if_inst      = '0;
        ex_valid     = 1'b0;
        ex_taken     = 1'b0;
        ex_pc        = '0;
        ex_target    = '0;
        cycle_cnt    = 0;
        err_cnt      = 0;
        err_at_start = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        for (int i = 0; i < BIM_ENTRIES; i++) begin
            m_ctr[i] = CTR_RESET;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_tgt[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            inst = $random(seed);
            fetch(rand_addr(), {inst[31:7], OPC_OPIMM}, 32'd0);
        end
        end_test("non-control");

        pc_a  = rand_pc(6'd1);
        tgt_a = rand_addr();
        off   = 32'hffff_ffa0;   // backward loop branch
        inst  = enc_b(off[12:0]);
        fetch(pc_a, inst, off);
        train(pc_a, inst, off, 1'b1, tgt_a);
        fetch(pc_a, inst, off);
        train(pc_a, inst, off, 1'b0, tgt_a);
        train(pc_a, inst, off, 1'b0, tgt_a);
        fetch(pc_a, inst, off);
        end_test("branch direction");

        pc_a  = rand_pc(6'd2);
        tgt_a = rand_addr();
        off   = 32'd200;
        inst  = enc_b(off[12:0]);
        repeat (3) train(pc_a, inst, off, 1'b1, tgt_a);
        fetch(pc_a, inst, off);
        train(pc_a, inst, off, 1'b0, tgt_a);
        fetch(pc_a, inst, off);
        end_test("hysteresis");

        pc_a  = rand_pc(6'd3);
        tgt_a = rand_addr();
        off   = 32'h0004_5678;
        inst  = enc_j(off[20:0]);
        fetch(pc_a, inst, off);
        train(pc_a, inst, off, 1'b1, tgt_a);
        fetch(pc_a, inst, off);
        end_test("jal");

        pc_a  = rand_pc(6'd4);
        pc_b  = pc_a ^ 32'h0000_0040;   // same buffer slot with another tag
        tgt_a = rand_addr();
        tgt_b = rand_addr();
        off   = 32'h0000_0120;
        inst  = enc_b(off[12:0]);
        train(pc_a, inst, off, 1'b1, tgt_a);
        fetch(pc_a, inst, off);
        train(pc_b, inst, off, 1'b1, tgt_b);
        fetch(pc_a, inst, off);
        fetch(pc_b, inst, off);
        end_test("aliasing");

        pc_a  = rand_pc(6'd5);
        tgt_a = rand_addr();
        inst  = {12'd0, 5'd1, 3'b000, 5'd0, OPC_JALR};
        fetch(pc_a, inst, 32'd0);
        train(pc_a, inst, 32'd0, 1'b1, tgt_a);
        fetch(pc_a, inst, 32'd0);
        end_test("jalr");

        $display("tests ok %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
